// ==== logic/lstm_params.svh ====
/*
 * LSTM cell constants
 * Array sizes, quantization scales and zero points shared by the datapath
 */
`ifndef LSTM_PARAMS_SVH
`define LSTM_PARAMS_SVH

// Array sizes
`define LSTM_UNITS        8
`define LSTM_DOT_LEN      16
`define LSTM_ROWS         32

// Zero points of data, state, weights and tanh codes
`define LSTM_CODE_ZERO    128
`define LSTM_BIAS_ZERO    0

// Input side scales
`define LSTM_SCALE_DATA   128
`define LSTM_SCALE_STATE  128
`define LSTM_SCALE_W      128
`define LSTM_SCALE_B      256

// Activation input scales
`define LSTM_SCALE_SIG    24
`define LSTM_SCALE_TANH   48

// Activation output scales
`define LSTM_OUT_SCALE_SIG   256
`define LSTM_OUT_SCALE_TANH  128

// Hard activation slope, 8/3 in code units
`define LSTM_ACT_NUM      8
`define LSTM_ACT_DEN      3

`endif

// ==== logic/lstm_pkg.sv ====
/*
 * LSTM cell types
 * Gate identifiers, pipeline records and the shared code arithmetic
 */
`include "lstm_params.svh"

package lstm_pkg;

	typedef enum logic [1:0] {
		gate_i = 2'd0,
		gate_f = 2'd1,
		gate_g = 2'd2,
		gate_o = 2'd3
	} gate_e;

	// Row identity travelling down the pipeline
	typedef struct packed {
		logic        valid;
		logic [2:0]  unit;
		gate_e       gate;
	} gate_tag_t;

	// One parameter store write
	typedef struct packed {
		logic          weight_we;
		logic          bias_we;
		logic [4:0]    row;
		logic [127:0]  weights;
		logic [7:0]    bias;
	} param_wr_t;

	typedef struct packed {
		gate_tag_t           tag;
		logic signed [19:0]  sum;
		logic [7:0]          bias;
	} gate_acc_t;

	typedef struct packed {
		gate_tag_t   tag;
		logic [7:0]  code;
	} gate_act_t;

	// Clip to an 8-bit code
	function automatic logic [7:0] sat_code(input int value);
		if (value < 0)
			return 8'd0;
		if (value > 255)
			return 8'd255;
		return value[7:0];
	endfunction

	// Piecewise linear sigmoid/tanh, same code mapping for both
	function automatic logic [7:0] hard_act(input logic [7:0] pre);
		int slope;
		slope = ((int'(pre) - `LSTM_CODE_ZERO) * `LSTM_ACT_NUM) / `LSTM_ACT_DEN;
		return sat_code(`LSTM_CODE_ZERO + slope);
	endfunction

endpackage

// ==== logic/param_loader.sv ====
/*
 * Init byte stream to parameter store writes
 * Weights arrive 16 bytes per row MSB first, biases one byte per row
 */
`include "lstm_params.svh"

module param_loader (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 init_valid,
	input  logic [7:0]           init_data,
	input  logic                 init_type,
	output lstm_pkg::param_wr_t  wr
);

	logic          valid_q;
	logic [3:0]    byte_cnt;
	logic [4:0]    row_cnt;
	logic [4:0]    bias_cnt;
	logic          weight_we;
	logic          bias_we;
	logic [4:0]    row_q;
	logic [127:0]  row_buf;

	logic          burst_start;
	logic [3:0]    byte_idx;
	logic [4:0]    row_idx;
	logic [4:0]    bias_idx;
	logic          row_full;

	// Counters restart on the first byte of every burst
	assign burst_start = init_valid && !valid_q;
	assign byte_idx    = burst_start ? 4'd0 : byte_cnt;
	assign row_idx     = burst_start ? 5'd0 : row_cnt;
	assign bias_idx    = burst_start ? 5'd0 : bias_cnt;
	assign row_full    = (byte_idx == 4'(`LSTM_DOT_LEN - 1));

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			valid_q   <= 1'b0;
			byte_cnt  <= '0;
			row_cnt   <= '0;
			bias_cnt  <= '0;
			weight_we <= 1'b0;
			bias_we   <= 1'b0;
		end else begin
			valid_q   <= init_valid;
			weight_we <= init_valid && !init_type && row_full;
			bias_we   <= init_valid && init_type;
			if (init_valid) begin
				byte_cnt <= byte_idx + 4'd1;
				row_cnt  <= row_idx + 5'(row_full && !init_type);
				bias_cnt <= bias_idx + 5'(init_type);
			end
		end
	end

	// Shift register doubles as the bias byte holder
	always_ff @(posedge clk) begin
		if (init_valid) begin
			row_buf <= {row_buf[119:0], init_data};
			row_q   <= init_type ? bias_idx : row_idx;
		end
	end

	always_comb begin
		wr.weight_we = weight_we;
		wr.bias_we   = bias_we;
		wr.row       = row_q;
		wr.weights   = row_buf;
		wr.bias      = row_buf[7:0];
	end

endmodule

// ==== logic/param_store.sv ====
/*
 * Weight and bias memories, one 128-bit row and one bias per gate row
 * Registered read, one cycle latency
 */
`include "lstm_params.svh"

module param_store (
	input  logic                 clk,
	input  logic                 resetn,
	input  lstm_pkg::param_wr_t  wr,
	input  logic                 rd_en,
	input  logic [4:0]           rd_row,
	output logic [127:0]         rd_weights,
	output logic [7:0]           rd_bias
);

	logic [127:0]  weight_mem [`LSTM_ROWS];
	logic [7:0]    bias_mem   [`LSTM_ROWS];

	always_ff @(posedge clk) begin
		if (wr.weight_we)
			weight_mem[wr.row] <= wr.weights;
		if (wr.bias_we)
			bias_mem[wr.row] <= wr.bias;
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_weights <= weight_mem[rd_row];
			rd_bias    <= bias_mem[rd_row];
		end
	end

	// Loader and sequencer share the store with no arbiter
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (!resetn)
		(wr.weight_we || wr.bias_we) |-> !rd_en);

endmodule

// ==== logic/step_sequencer.sv ====
/*
 * Step control
 * Accepts a step, issues the 32 gate rows in order and holds done
 */
`include "lstm_params.svh"

module step_sequencer (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 next_valid,
	input  logic                 init_valid,
	input  logic                 step_end,
	output logic                 done,
	output logic                 start,
	output logic                 rd_en,
	output logic [4:0]           rd_row,
	output lstm_pkg::gate_tag_t  tag
);

	logic        issuing;
	logic [4:0]  cnt;

	// Accept only when idle and no parameter load is running
	assign start  = next_valid && done && !init_valid;
	assign rd_en  = issuing;
	assign rd_row = cnt;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			done    <= 1'b1;
			issuing <= 1'b0;
			cnt     <= '0;
		end else begin
			if (start) begin
				done    <= 1'b0;
				issuing <= 1'b1;
				cnt     <= '0;
			end else if (issuing) begin
				cnt <= cnt + 5'd1;
				if (cnt == 5'(`LSTM_ROWS - 1))
					issuing <= 1'b0;
			end
			// Last o gate has been folded into the state
			if (step_end)
				done <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Row tag, delayed one cycle to line up with the store read
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			tag <= '0;
		end else begin
			tag.valid <= issuing;
			tag.unit  <= cnt[4:2];
			tag.gate  <= lstm_pkg::gate_e'(cnt[1:0]);
		end
	end

	a_end_while_busy: assert property (@(posedge clk) disable iff (!resetn)
		step_end |-> !done);

endmodule

// ==== logic/gate_dot_product.sv ====
/*
 * Zero-corrected 16-term dot product of one gate row
 * Terms are the eight step inputs followed by the eight previous hidden codes
 */
`include "lstm_params.svh"

module gate_dot_product (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 start,
	input  logic [63:0]          data_in,
	input  logic [63:0]          h_prev,
	input  logic [127:0]         weights,
	input  logic [7:0]           bias,
	input  lstm_pkg::gate_tag_t  tag_in,
	output lstm_pkg::gate_acc_t  acc
);

	logic [63:0]          data_q;
	logic signed [19:0]   sum_next;
	lstm_pkg::gate_tag_t  tag_q;
	logic signed [19:0]   sum_q;
	logic [7:0]           bias_q;

	always_ff @(posedge clk) begin
		if (start)
			data_q <= data_in;
	end

	always_comb begin
		int total;
		logic [7:0] a_code;
		logic [7:0] w_code;
		total = 0;
		for (int k = 0; k < `LSTM_DOT_LEN; k++) begin
			if (k < `LSTM_UNITS)
				a_code = data_q[8*(`LSTM_UNITS-1-k) +: 8];
			else
				a_code = h_prev[8*(`LSTM_DOT_LEN-1-k) +: 8];
			w_code = weights[8*(`LSTM_DOT_LEN-1-k) +: 8];
			total += (int'(a_code) - `LSTM_CODE_ZERO) * (int'(w_code) - `LSTM_CODE_ZERO);
		end
		sum_next = 20'(total);
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			tag_q <= '0;
		else
			tag_q <= tag_in;
	end

	always_ff @(posedge clk) begin
		sum_q  <= sum_next;
		bias_q <= bias;
	end

	always_comb begin
		acc.tag  = tag_q;
		acc.sum  = sum_q;
		acc.bias = bias_q;
	end

endmodule

// ==== logic/gate_quantizer.sv ====
/*
 * Gate requantizer
 * Scales sum and bias to the activation input, saturates and applies hard act
 */
`include "lstm_params.svh"

module gate_quantizer (
	input  logic                 clk,
	input  logic                 resetn,
	input  lstm_pkg::gate_acc_t  acc,
	output lstm_pkg::gate_act_t  act
);

	logic [7:0]           pre_code;
	logic [7:0]           act_next;
	lstm_pkg::gate_tag_t  tag_q;
	logic [7:0]           code_q;

	always_comb begin
		int scale;
		int sum_term;
		int bias_term;
		// g feeds tanh, the other gates feed sigmoid
		if (acc.tag.gate == lstm_pkg::gate_g)
			scale = `LSTM_SCALE_TANH;
		else
			scale = `LSTM_SCALE_SIG;
		sum_term  = (int'($signed(acc.sum)) * scale) / (`LSTM_SCALE_W * `LSTM_SCALE_DATA);
		bias_term = ((int'(acc.bias) - `LSTM_BIAS_ZERO) * scale) / `LSTM_SCALE_B;
		pre_code  = lstm_pkg::sat_code(sum_term + bias_term + `LSTM_CODE_ZERO);
		act_next  = lstm_pkg::hard_act(pre_code);
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			tag_q <= '0;
		else
			tag_q <= acc.tag;
	end

	always_ff @(posedge clk) begin
		code_q <= act_next;
	end

	always_comb begin
		act.tag  = tag_q;
		act.code = code_q;
	end

endmodule

// ==== logic/state_update.sv ====
/*
 * Cell and hidden state update
 * Collects i, f, g per unit and folds them in when the o gate arrives
 */
`include "lstm_params.svh"

module state_update (
	input  logic                 clk,
	input  logic                 resetn,
	input  lstm_pkg::gate_act_t  act,
	output logic [63:0]          c_out,
	output logic [63:0]          h_out,
	output logic                 step_end
);

	logic [7:0]  i_q;
	logic [7:0]  f_q;
	logic [7:0]  g_q;
	logic [7:0]  c_mem  [`LSTM_UNITS];
	logic [7:0]  h_mem  [`LSTM_UNITS];
	logic [7:0]  h_pend [`LSTM_UNITS];
	logic [7:0]  c_new;
	logic [7:0]  t_code;
	logic [7:0]  h_new;
	logic        o_hit;

	assign o_hit = act.tag.valid && (act.tag.gate == lstm_pkg::gate_o);

	always_ff @(posedge clk) begin
		if (act.tag.valid) begin
			case (act.tag.gate)
				lstm_pkg::gate_i: i_q <= act.code;
				lstm_pkg::gate_f: f_q <= act.code;
				lstm_pkg::gate_g: g_q <= act.code;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////
	// c' = f*c + i*g, h' = o*tanh(c'), all in code arithmetic
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		int fc_term;
		int ig_term;
		int t_pre;
		int oh_term;
		fc_term = ((int'(c_mem[act.tag.unit]) - `LSTM_CODE_ZERO) * int'(f_q))
			/ `LSTM_OUT_SCALE_SIG;
		ig_term = (int'(i_q) * (int'(g_q) - `LSTM_CODE_ZERO) * `LSTM_SCALE_STATE)
			/ (`LSTM_OUT_SCALE_SIG * `LSTM_OUT_SCALE_TANH);
		c_new = lstm_pkg::sat_code(fc_term + ig_term + `LSTM_CODE_ZERO);
		t_pre = ((int'(c_new) - `LSTM_CODE_ZERO) * `LSTM_SCALE_TANH) / `LSTM_SCALE_STATE;
		t_code = lstm_pkg::hard_act(lstm_pkg::sat_code(t_pre + `LSTM_CODE_ZERO));
		oh_term = (int'(act.code) * (int'(t_code) - `LSTM_CODE_ZERO) * `LSTM_SCALE_DATA)
			/ (`LSTM_OUT_SCALE_TANH * `LSTM_OUT_SCALE_SIG);
		h_new = lstm_pkg::sat_code(oh_term + `LSTM_CODE_ZERO);
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			for (int u = 0; u < `LSTM_UNITS; u++) begin
				c_mem[u]  <= 8'(`LSTM_CODE_ZERO);
				h_mem[u]  <= 8'(`LSTM_CODE_ZERO);
				h_pend[u] <= 8'(`LSTM_CODE_ZERO);
			end
			step_end <= 1'b0;
		end else begin
			step_end <= 1'b0;
			if (o_hit) begin
				c_mem[act.tag.unit] <= c_new;
				// Hidden codes stay frozen until the last unit is done
				if (act.tag.unit == 3'(`LSTM_UNITS - 1)) begin
					for (int u = 0; u < `LSTM_UNITS - 1; u++)
						h_mem[u] <= h_pend[u];
					h_mem[`LSTM_UNITS-1] <= h_new;
					step_end <= 1'b1;
				end else begin
					h_pend[act.tag.unit] <= h_new;
				end
			end
		end
	end

	// Unit 0 in the top byte
	always_comb begin
		for (int u = 0; u < `LSTM_UNITS; u++) begin
			c_out[8*(`LSTM_UNITS-1-u) +: 8] = c_mem[u];
			h_out[8*(`LSTM_UNITS-1-u) +: 8] = h_mem[u];
		end
	end

	// Sequencer row order must survive the pipeline
	a_gate_order: assert property (@(posedge clk) disable iff (!resetn)
		act.tag.valid && (act.tag.gate != lstm_pkg::gate_i) |->
		$past(act.tag.valid) && ($past(act.tag.unit) == act.tag.unit) &&
		(2'($past(act.tag.gate) + 2'd1) == 2'(act.tag.gate)));

endmodule

// ==== logic/lstm_cell_top.sv ====
/*
 * Quantized LSTM cell, eight hidden units
 * Parameter load path plus a pipelined one-row-per-cycle step datapath
 */
module lstm_cell_top (
	input  logic         clk,
	input  logic         resetn,
	input  logic         init_valid,
	input  logic [7:0]   init_data,
	input  logic         init_type,
	input  logic         next_valid,
	input  logic [63:0]  data_in,
	output logic         done,
	output logic [63:0]  c_out,
	output logic [63:0]  h_out
);

	lstm_pkg::param_wr_t  wr;
	lstm_pkg::gate_tag_t  tag;
	lstm_pkg::gate_acc_t  acc;
	lstm_pkg::gate_act_t  act;
	logic                 start;
	logic                 rd_en;
	logic [4:0]           rd_row;
	logic [127:0]         rd_weights;
	logic [7:0]           rd_bias;
	logic                 step_end;

	param_loader u_loader (
		.clk(clk), .resetn(resetn),
		.init_valid(init_valid), .init_data(init_data), .init_type(init_type),
		.wr(wr)
	);

	param_store u_store (
		.clk(clk), .resetn(resetn), .wr(wr),
		.rd_en(rd_en), .rd_row(rd_row),
		.rd_weights(rd_weights), .rd_bias(rd_bias)
	);

	step_sequencer u_seq (
		.clk(clk), .resetn(resetn),
		.next_valid(next_valid), .init_valid(init_valid), .step_end(step_end),
		.done(done), .start(start), .rd_en(rd_en), .rd_row(rd_row), .tag(tag)
	);

	gate_dot_product u_dot (
		.clk(clk), .resetn(resetn), .start(start),
		.data_in(data_in), .h_prev(h_out),
		.weights(rd_weights), .bias(rd_bias), .tag_in(tag),
		.acc(acc)
	);

	gate_quantizer u_quant (
		.clk(clk), .resetn(resetn), .acc(acc), .act(act)
	);

	state_update u_state (
		.clk(clk), .resetn(resetn), .act(act),
		.c_out(c_out), .h_out(h_out), .step_end(step_end)
	);

endmodule

// ==== bench/lstm_model.svh ====
/*
 * LSTM reference arithmetic for the testbench
 * Code-domain gate, cell and hidden rules with truncating signed division
 */
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

// Clip into the 8-bit code range
function automatic logic [7:0] clip_code(input int v);
	if (v < 0)
		return 8'd0;
	if (v > 255)
		return 8'd255;
	return 8'(v);
endfunction

// Hard sigmoid and hard tanh share one code mapping
function automatic logic [7:0] hard_activation(input logic [7:0] p);
	int d;
	d = ((int'(p) - 128) * 8) / 3;
	return clip_code(128 + d);
endfunction

// Weight byte k is MSB first, inputs then previous hidden codes
function automatic int row_sum(input logic [127:0] w, input logic [63:0] x,
		input logic [63:0] h);
	int s;
	int a;
	s = 0;
	for (int k = 0; k < 16; k++) begin
		a = (k < 8) ? int'(x[63-8*k -: 8]) : int'(h[63-8*(k-8) -: 8]);
		s += (a - 128) * (int'(w[127-8*k -: 8]) - 128);
	end
	return s;
endfunction

function automatic logic [7:0] gate_code(input int sum, input logic [7:0] b, input int s);
	int pre;
	pre = (sum * s) / 16384 + (int'(b) * s) / 256 + 128;
	return hard_activation(clip_code(pre));
endfunction

function automatic logic [7:0] cell_code(input logic [7:0] c, input logic [7:0] i,
		input logic [7:0] f, input logic [7:0] g);
	int fc;
	int ig;
	fc = ((int'(c) - 128) * int'(f)) / 256;
	ig = (int'(i) * (int'(g) - 128) * 128) / 32768;
	return clip_code(fc + ig + 128);
endfunction

function automatic logic [7:0] hidden_code(input logic [7:0] c_new, input logic [7:0] o);
	logic [7:0] t;
	t = hard_activation(clip_code(((int'(c_new) - 128) * 48) / 128 + 128));
	return clip_code((int'(o) * (int'(t) - 128) * 128) / 32768 + 128);
endfunction

`endif

// ==== bench/lstm_cell_tb.sv ====
/*
 * LSTM cell testbench
 * Table of steps with loads in between, checked against the reference model
 */
`include "lstm_params.svh"

module lstm_cell_tb;

	`include "lstm_model.svh"

	localparam int TABLE_LEN   = 10;
	localparam int LOAD_CYCLES = 3 * (`LSTM_ROWS * (`LSTM_DOT_LEN + 1) + 8);
	localparam int CYCLE_LIMIT = 40 * TABLE_LEN + LOAD_CYCLES + 200;
	localparam logic [63:0] STATE_RESET = {8{8'd128}};

	// One step of the table
	typedef struct packed {
		logic         load_w;
		logic         load_b;
		logic         sat_w;
		logic         extra_pulse;
		logic [63:0]  data;
		logic [63:0]  exp_c;
		logic [63:0]  exp_h;
	} step_row_t;

	logic          clk;
	logic          resetn;
	logic          init_valid;
	logic [7:0]    init_data;
	logic          init_type;
	logic          next_valid;
	logic [63:0]   data_in;
	logic          done;
	logic [63:0]   c_out;
	logic [63:0]   h_out;

	step_row_t     steps [TABLE_LEN];
	logic [127:0]  w_tab [TABLE_LEN][`LSTM_ROWS];
	logic [7:0]    b_tab [TABLE_LEN][`LSTM_ROWS];
	int            seed;
	int            cycle_count = 0;

	lstm_cell_top u_dut (
		.clk(clk), .resetn(resetn),
		.init_valid(init_valid), .init_data(init_data), .init_type(init_type),
		.next_valid(next_valid), .data_in(data_in),
		.done(done), .c_out(c_out), .h_out(h_out)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the step table never finished", cycle_count);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	task automatic report_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected values
	//////////////////////////////////////////////////////////////////////

	// One recurrent step with the parameters in force at table row n
	task automatic predict_step(input int n, inout logic [63:0] c, inout logic [63:0] h);
		logic [7:0]   gates [4];
		logic [7:0]   c_new;
		logic [63:0]  h_next;
		int           r;
		h_next = h;
		for (int u = 0; u < `LSTM_UNITS; u++) begin
			for (int g = 0; g < 4; g++) begin
				r = 4 * u + g;
				gates[g] = gate_code(row_sum(w_tab[n][r], steps[n].data, h), b_tab[n][r],
					(g == 2) ? 48 : 24);
			end
			c_new = cell_code(c[63-8*u -: 8], gates[0], gates[1], gates[2]);
			c[63-8*u -: 8] = c_new;
			h_next[63-8*u -: 8] = hidden_code(c_new, gates[3]);
		end
		h = h_next;
	endtask

	task automatic build_table();
		logic [127:0]  w_model [`LSTM_ROWS];
		logic [7:0]    b_model [`LSTM_ROWS];
		logic [63:0]   c_model;
		logic [63:0]   h_model;
		c_model = STATE_RESET;
		h_model = STATE_RESET;
		for (int n = 0; n < TABLE_LEN; n++) begin
			steps[n] = '0;
			steps[n].load_w      = (n == 0) || (n == 7);
			steps[n].load_b      = (n == 0) || (n == 9);
			steps[n].sat_w       = (n == 7);
			steps[n].extra_pulse = (n == 8);
			steps[n].data        = {$random(seed), $random(seed)};
			// Saturation case drives full-scale inputs of both signs
			if (steps[n].sat_w)
				steps[n].data = 64'hff00_ff00_ff00_ff00;
			for (int r = 0; r < `LSTM_ROWS; r++) begin
				if (steps[n].load_w)
					w_model[r] = steps[n].sat_w ? {128{1'b1}} :
						{$random(seed), $random(seed), $random(seed), $random(seed)};
				if (steps[n].load_b)
					b_model[r] = 8'($random(seed));
				w_tab[n][r] = w_model[r];
				b_tab[n][r] = b_model[r];
			end
			predict_step(n, c_model, h_model);
			steps[n].exp_c = c_model;
			steps[n].exp_h = h_model;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic send_weights(input int n);
		for (int r = 0; r < `LSTM_ROWS; r++) begin
			for (int k = 0; k < `LSTM_DOT_LEN; k++) begin
				@(posedge clk);
				init_valid <= 1'b1;
				init_type  <= 1'b0;
				init_data  <= w_tab[n][r][127-8*k -: 8];
			end
		end
		@(posedge clk);
		init_valid <= 1'b0;
		// Gap so the next burst restarts the row counters
		repeat (2) @(posedge clk);
	endtask

	task automatic send_biases(input int n);
		for (int r = 0; r < `LSTM_ROWS; r++) begin
			@(posedge clk);
			init_valid <= 1'b1;
			init_type  <= 1'b1;
			init_data  <= b_tab[n][r];
		end
		@(posedge clk);
		init_valid <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic run_step(input int n);
		@(posedge clk);
		next_valid <= 1'b1;
		data_in    <= steps[n].data;
		@(posedge clk);
		next_valid <= 1'b0;
		@(posedge clk);
		assert (!done) else report_error($sformatf("step %0d was not accepted", n));
		// A pulse with other data while busy must be ignored
		if (steps[n].extra_pulse) begin
			next_valid <= 1'b1;
			data_in    <= ~steps[n].data;
			@(posedge clk);
			next_valid <= 1'b0;
		end
		do
			@(posedge clk);
		while (!done);
		assert (c_out == steps[n].exp_c) else
			report_error($sformatf("step %0d c_out %h, expected %h", n, c_out, steps[n].exp_c));
		assert (h_out == steps[n].exp_h) else
			report_error($sformatf("step %0d h_out %h, expected %h", n, h_out, steps[n].exp_h));
	endtask

	initial begin
		clk        = 1'b0;
		resetn     = 1'b0;
		init_valid = 1'b0;
		init_data  = '0;
		init_type  = 1'b0;
		next_valid = 1'b0;
		data_in    = '0;
		seed       = 32'h4eda;
		build_table();
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		assert (done) else report_error("done is low after reset");
		assert (c_out == STATE_RESET) else
			report_error($sformatf("c_out %h after reset, expected %h", c_out, STATE_RESET));
		assert (h_out == STATE_RESET) else
			report_error($sformatf("h_out %h after reset, expected %h", h_out, STATE_RESET));
		for (int n = 0; n < TABLE_LEN; n++) begin
			if (steps[n].load_w)
				send_weights(n);
			if (steps[n].load_b)
				send_biases(n);
			run_step(n);
		end
		repeat (2) @(posedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== lstm_cell.f ====
+incdir+logic
+incdir+bench
logic/lstm_pkg.sv
logic/param_loader.sv
logic/param_store.sv
logic/step_sequencer.sv
logic/gate_dot_product.sv
logic/gate_quantizer.sv
logic/state_update.sv
logic/lstm_cell_top.sv
bench/lstm_cell_tb.sv

// ==== Makefile ====
# Verilator build and run of the LSTM cell testbench

VERILATOR ?= verilator
TOP       ?= lstm_cell_tb
FILELIST  ?= lstm_cell.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
